/* Makefile */
# Verilator flow for the core control block testbench

VERILATOR  ?= verilator
FILELIST   := tb.f
TOP        := tb_radio_core_ctrl
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the simulator is the result
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* core_pkg.sv */
/*
 * shared widths, settings addresses and readback constants for the core
 * control block. all addresses are on the 8-bit settings bus; the SPI
 * master takes three consecutive addresses from SR_CORE_SPI.
 */
package core_pkg;

    ////////////////////
    // bus and readback widths
    ////////////////////
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;
    typedef logic [63:0] rb_word_t;
    typedef logic [1:0]  rb_sel_t;
    typedef logic [1:0]  pps_sel_t;

    // SPI master FSM
    typedef enum logic [0:0] {
        SPI_IDLE,
        SPI_SHIFT
    } spi_state_t;

    ////////////////////
    // settings addresses
    ////////////////////
    // SPI uses +0 divider, +1 config, +2 data/start
    localparam set_addr_t SR_CORE_SPI      = 8'd8;
    localparam set_addr_t SR_CORE_MISC     = 8'd16;
    localparam set_addr_t SR_CORE_READBACK = 8'd32;
    localparam set_addr_t SR_CORE_GPSDO_ST = 8'd40;
    // bits 1:0 pps select, bit 2 time sync
    localparam set_addr_t SR_CORE_SYNC     = 8'd48;

    // pps source codes
    localparam pps_sel_t PPS_SEL_GPSDO    = 2'd0;
    localparam pps_sel_t PPS_SEL_EXT      = 2'd1;
    localparam pps_sel_t PPS_SEL_INTERNAL = 2'd2;
    localparam pps_sel_t PPS_SEL_NONE     = 2'd3;

    ////////////////////
    // readback constants
    ////////////////////
    localparam logic [31:0] CORE_SIGNATURE = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR   = 16'd13;
    localparam logic [15:0] COMPAT_MINOR   = 16'd0;
    localparam logic [7:0]  RADIO_STATUS   = 8'd1;

endpackage

/* core_readback.sv */
`timescale 1ns/1ps
/*
 * readback word selector. the output is combinational from the select
 * and its sources; only the front-end lock bits are synchronized here,
 * all other inputs are assumed to be on radio_clk already.
 */
module core_readback
    import core_pkg::*;
(
    input  logic       i_radio_clk,
    input  logic       i_bus_rst,
    input  rb_sel_t    i_rb_sel,
    input  set_data_t  i_spi_readback,
    input  logic [7:0] i_gpsdo_st,
    input  set_data_t  i_rb_misc,
    input  logic [1:0] i_lock_signals,
    output rb_word_t   o_rb_data
);

    logic [1:0] lock_meta;
    logic [1:0] lock_sync;

    // lock bits from the front end are asynchronous
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    ////////////////////
    // word select
    ////////////////////
    always_comb begin
        case (i_rb_sel)
            2'd0:    o_rb_data = {CORE_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1:    o_rb_data = {32'd0, i_spi_readback};
            2'd2:    o_rb_data = {16'd0, RADIO_STATUS, i_gpsdo_st, i_rb_misc};
            2'd3:    o_rb_data = {62'd0, lock_sync};
            default: o_rb_data = '0;
        endcase
    end

endmodule

/* pps_generator.sv */
`timescale 1ns/1ps
/*
 * internal pps square wave, period CLK_FREQ cycles, high for the first
 * half. CLK_FREQ must be at least 2; odd values give a short high phase.
 */
module pps_generator #(
    parameter int CLK_FREQ = 100_000_000
) (
    input  logic i_radio_clk,
    input  logic i_bus_rst,
    output logic o_pps
);
    localparam int CNT_W = $clog2(CLK_FREQ);

    logic [CNT_W-1:0] cnt;

    // wraps every CLK_FREQ cycles, phase starts at reset release
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst || (cnt == CNT_W'(CLK_FREQ - 1))) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_pps = (cnt < CNT_W'(CLK_FREQ / 2));

endmodule

/* pps_source_select.sv */
`timescale 1ns/1ps
/*
 * double-flops the gpsdo, external and internal pps and muxes one out.
 * the pins are assumed asynchronous; the mux itself is combinational, so
 * a select change can cut a pulse short.
 */
module pps_source_select
    import core_pkg::*;
(
    input  logic     i_radio_clk,
    input  logic     i_bus_rst,
    input  pps_sel_t i_pps_sel,
    input  logic     i_pps_gpsdo,
    input  logic     i_pps_ext,
    input  logic     i_pps_internal,
    output logic     o_pps
);

    // bit 0 gpsdo, bit 1 external, bit 2 internal
    logic [2:0] pps_meta;
    logic [2:0] pps_sync;

    ////////////////////
    // two-flop synchronizers
    ////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            pps_meta <= '0;
            pps_sync <= '0;
        end else begin
            pps_meta <= {i_pps_internal, i_pps_ext, i_pps_gpsdo};
            pps_sync <= pps_meta;
        end
    end

    // source mux
    always_comb begin
        case (i_pps_sel)
            PPS_SEL_GPSDO:    o_pps = pps_sync[0];
            PPS_SEL_EXT:      o_pps = pps_sync[1];
            PPS_SEL_INTERNAL: o_pps = pps_sync[2];
            PPS_SEL_NONE:     o_pps = 1'b0;
            default:          o_pps = 1'b0;
        endcase
    end

endmodule

/* radio_core_ctrl.sv */
`timescale 1ns/1ps
/*
 * core control block on a single clock (radio_clk) and reset (bus_rst).
 * settings strobe writes misc, readback select, gpsdo status, sync and
 * SPI registers. gpsdo status keeps its value through reset. the pps
 * pins are treated as asynchronous; nothing here applies back-pressure.
 */
module radio_core_ctrl
    import core_pkg::*;
#(
    parameter int PPS_CLK_FREQ = 100_000_000,
    parameter int NUM_SLAVES   = 8
) (
    input  logic                  i_radio_clk,
    input  logic                  i_bus_rst,
    input  logic                  i_set_stb,
    input  set_addr_t             i_set_addr,
    input  set_data_t             i_set_data,
    input  logic                  i_pps_gpsdo,
    input  logic                  i_pps_ext,
    input  set_data_t             i_rb_misc,
    input  logic [1:0]            i_lock_signals,
    input  logic                  i_miso,
    output logic [NUM_SLAVES-1:0] o_sen,
    output logic                  o_sclk,
    output logic                  o_mosi,
    output logic                  o_spi_ready,
    output set_data_t             o_misc_outs,
    output logic                  o_pps,
    output logic                  o_time_sync,
    output rb_word_t              o_rb_data
);

    rb_sel_t    rb_sel;
    logic [7:0] gpsdo_st;
    pps_sel_t   pps_sel;
    logic       pps_internal;
    set_data_t  spi_readback;

    ////////////////////
    // settings registers
    ////////////////////
    setting_reg #(.ADDR(SR_CORE_MISC), .WIDTH(32), .AT_RESET(32'h0)) u_sr_misc (
        .i_radio_clk, .i_bus_rst, .i_set_stb, .i_set_addr, .i_set_data,
        .o_value     (o_misc_outs)
    );

    setting_reg #(.ADDR(SR_CORE_READBACK), .WIDTH(2)) u_sr_readback (
        .i_radio_clk, .i_bus_rst, .i_set_stb, .i_set_addr, .i_set_data,
        .o_value     (rb_sel)
    );

    // status written by host software, must survive a core reset
    setting_reg #(.ADDR(SR_CORE_GPSDO_ST), .WIDTH(8), .KEEP_ON_RESET(1'b1)) u_sr_gpsdo_st (
        .i_radio_clk, .i_bus_rst, .i_set_stb, .i_set_addr, .i_set_data,
        .o_value     (gpsdo_st)
    );

    // time sync goes straight out, same clock as the radio
    setting_reg #(.ADDR(SR_CORE_SYNC), .WIDTH(3)) u_sr_sync (
        .i_radio_clk, .i_bus_rst, .i_set_stb, .i_set_addr, .i_set_data,
        .o_value     ({o_time_sync, pps_sel})
    );

    ////////////////////
    // pps path
    ////////////////////
    pps_generator #(.CLK_FREQ(PPS_CLK_FREQ)) u_pps_gen (
        .i_radio_clk, .i_bus_rst,
        .o_pps       (pps_internal)
    );

    pps_source_select u_pps_sel (
        .i_radio_clk, .i_bus_rst,
        .i_pps_sel      (pps_sel),
        .i_pps_gpsdo,
        .i_pps_ext,
        .i_pps_internal (pps_internal),
        .o_pps
    );

    // peripheral SPI
    spi_master #(.BASE(SR_CORE_SPI), .NUM_SLAVES(NUM_SLAVES)) u_spi (
        .i_radio_clk, .i_bus_rst, .i_set_stb, .i_set_addr, .i_set_data,
        .o_sen, .o_sclk, .o_mosi, .i_miso,
        .o_ready     (o_spi_ready),
        .o_readback  (spi_readback)
    );

    core_readback u_readback (
        .i_radio_clk, .i_bus_rst,
        .i_rb_sel       (rb_sel),
        .i_spi_readback (spi_readback),
        .i_gpsdo_st     (gpsdo_st),
        .i_rb_misc,
        .i_lock_signals,
        .o_rb_data
    );

endmodule

/* radio_core_ctrl_assertions.sv */
`timescale 1ns/1ps
/*
 * concurrent checks bound into the core control block. SPI pins must be
 * idle while the master is ready, and misc outputs track the last misc
 * write. fail_count counts failed assertions.
 */
module radio_core_ctrl_assertions
    import core_pkg::*;
#(
    parameter int NUM_SLAVES = 8
) (
    input logic                  i_radio_clk,
    input logic                  i_bus_rst,
    input logic                  i_set_stb,
    input set_addr_t             i_set_addr,
    input set_data_t             i_set_data,
    input logic [NUM_SLAVES-1:0] i_sen,
    input logic                  i_sclk,
    input logic                  i_spi_ready,
    input set_data_t             i_misc_outs
);

    int        fail_count = 0;
    logic      misc_stb;
    set_data_t misc_shadow;

    assign misc_stb = i_set_stb && (i_set_addr == SR_CORE_MISC);

    // last value written to the misc address
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            misc_shadow <= '0;
        end else if (misc_stb) begin
            misc_shadow <= i_set_data;
        end
    end

    ////////////////////
    // SPI pins
    ////////////////////
    idle_pins: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        i_spi_ready |-> ((i_sen == '1) && !i_sclk))
    else begin
        fail_count = fail_count + 1;
        $error("SPI select or clock active while the master is ready");
    end

    ////////////////////
    // misc register
    ////////////////////
    misc_follows: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        misc_stb |=> (i_misc_outs == misc_shadow))
    else begin
        fail_count = fail_count + 1;
        $error("misc outputs differ from the last misc write");
    end

    misc_hold: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        !misc_stb |=> $stable(i_misc_outs))
    else begin
        fail_count = fail_count + 1;
        $error("misc outputs changed without a misc write");
    end

endmodule

/* setting_reg.sv */
`timescale 1ns/1ps
/*
 * single settings register, loads the low WIDTH bits of the bus data
 * when the strobe carries its address. with KEEP_ON_RESET set, reset is
 * ignored and the register has no defined value until first written.
 */
module setting_reg
    import core_pkg::*;
#(
    parameter set_addr_t        ADDR          = 8'd0,
    parameter int               WIDTH         = 32,
    parameter logic [WIDTH-1:0] AT_RESET      = '0,
    parameter bit               KEEP_ON_RESET = 1'b0
) (
    input  logic             i_radio_clk,
    input  logic             i_bus_rst,
    input  logic             i_set_stb,
    input  set_addr_t        i_set_addr,
    input  set_data_t        i_set_data,
    output logic [WIDTH-1:0] o_value
);

    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst && !KEEP_ON_RESET) begin
            o_value <= AT_RESET;
        end else if (i_set_stb && (i_set_addr == ADDR)) begin
            // output follows one cycle after the strobe
            o_value <= i_set_data[WIDTH-1:0];
        end
    end

endmodule

/* spi_master.sv */
`timescale 1ns/1ps
/*
 * settings-programmed SPI master, mode 0, MSB first from data bit 31.
 * BASE+0 divider, BASE+1 config (mask 7:0, bits 13:8), BASE+2 starts.
 * NUM_SLAVES is at most 8. bit counts of 0 behave as 1. a start while
 * busy is dropped; rewriting divider or config mid-transfer is unsafe.
 */
module spi_master
    import core_pkg::*;
#(
    parameter set_addr_t BASE       = SR_CORE_SPI,
    parameter int        NUM_SLAVES = 8
) (
    input  logic                  i_radio_clk,
    input  logic                  i_bus_rst,
    input  logic                  i_set_stb,
    input  set_addr_t             i_set_addr,
    input  set_data_t             i_set_data,
    output logic [NUM_SLAVES-1:0] o_sen,
    output logic                  o_sclk,
    output logic                  o_mosi,
    input  logic                  i_miso,
    output logic                  o_ready,
    output set_data_t             o_readback
);
    localparam int        DIV_W     = 16;
    localparam int        CFG_W     = 14;
    localparam set_addr_t ADDR_DATA = set_addr_t'(BASE + 2);

    logic [DIV_W-1:0]      divider;
    logic [CFG_W-1:0]      cfg;
    logic [NUM_SLAVES-1:0] slave_mask;
    logic [5:0]            bit_count;

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       bits_left;
    set_data_t        shift_out;
    set_data_t        shift_in;

    logic start;
    logic half_done;
    logic sclk_rise;
    logic sclk_fall;
    logic last_bit;

    ////////////////////
    // divider and config registers
    ////////////////////
    setting_reg #(.ADDR(BASE), .WIDTH(DIV_W)) u_sr_divider (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_set_stb   (i_set_stb),
        .i_set_addr  (i_set_addr),
        .i_set_data  (i_set_data),
        .o_value     (divider)
    );

    setting_reg #(.ADDR(set_addr_t'(BASE + 1)), .WIDTH(CFG_W)) u_sr_config (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_set_stb   (i_set_stb),
        .i_set_addr  (i_set_addr),
        .i_set_data  (i_set_data),
        .o_value     (cfg)
    );

    assign slave_mask = cfg[NUM_SLAVES-1:0];
    assign bit_count  = cfg[13:8];

    assign start     = i_set_stb && (i_set_addr == ADDR_DATA) && (state == SPI_IDLE);
    // half period is divider+1 cycles
    assign half_done = (state == SPI_SHIFT) && (div_cnt == divider);
    assign sclk_rise = half_done && !o_sclk;
    assign sclk_fall = half_done && o_sclk;
    assign last_bit  = (bits_left <= 6'd1);
    assign o_ready   = (state == SPI_IDLE);

    ////////////////////
    // control FSM
    ////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            state     <= SPI_IDLE;
            o_sen     <= '1;
            o_sclk    <= 1'b0;
            o_mosi    <= 1'b0;
            div_cnt   <= '0;
            bits_left <= '0;
        end else if (start) begin
            state     <= SPI_SHIFT;
            o_sen     <= ~slave_mask;
            o_mosi    <= i_set_data[31];
            div_cnt   <= '0;
            bits_left <= bit_count;
        end else if (state == SPI_SHIFT) begin
            if (half_done) begin
                div_cnt <= '0;
                o_sclk  <= ~o_sclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // falling edge ends a bit
            if (sclk_fall && last_bit) begin
                state  <= SPI_IDLE;
                o_sen  <= '1;
                o_mosi <= 1'b0;
            end else if (sclk_fall) begin
                bits_left <= bits_left - 1'b1;
                o_mosi    <= shift_out[30];
            end
        end
    end

    // shift registers and readback
    always_ff @(posedge i_radio_clk) begin
        if (start) begin
            shift_out <= i_set_data;
            shift_in  <= '0;
        end else if (sclk_rise) begin
            shift_in <= {shift_in[30:0], i_miso};
        end else if (sclk_fall) begin
            shift_out <= {shift_out[30:0], 1'b0};
        end
        if (sclk_fall && last_bit) begin
            o_readback <= shift_in;
        end
    end

endmodule

/* tb.f */
core_pkg.sv
setting_reg.sv
pps_generator.sv
pps_source_select.sv
spi_master.sv
core_readback.sv
radio_core_ctrl.sv
radio_core_ctrl_assertions.sv
tb_radio_core_ctrl.sv

/* tb_radio_core_ctrl.sv */
`timescale 1ns/1ps
/*
 * testbench for the core control block. 40 ns clock, inputs change on the
 * falling edge, miso looped back from mosi. the internal pps runs at 20
 * cycles per period so its toggling shows in a short run.
 */
module tb_radio_core_ctrl;

    localparam int         PPS_CLK_FREQ = 20;
    localparam int         NUM_SLAVES   = 8;
    localparam logic [7:0] A_SPI_DIV    = 8'd8;
    localparam logic [7:0] A_SPI_CFG    = 8'd9;
    localparam logic [7:0] A_SPI_DATA   = 8'd10;
    localparam logic [7:0] A_MISC       = 8'd16;
    localparam logic [7:0] A_RB_SEL     = 8'd32;
    localparam logic [7:0] A_GPSDO_ST   = 8'd40;
    localparam logic [7:0] A_SYNC       = 8'd48;

    logic        radio_clk;
    logic        bus_rst;
    logic        set_stb;
    logic [7:0]  set_addr;
    logic [31:0] set_data;
    logic        pps_gpsdo;
    logic        pps_ext;
    logic [31:0] rb_misc;
    logic [1:0]  lock_signals;
    logic        miso;
    logic [7:0]  sen;
    logic        sclk;
    logic        mosi;
    logic        spi_ready;
    logic [31:0] misc_outs;
    logic        pps;
    logic        time_sync;
    logic [63:0] rb_data;

    logic [31:0] lcg_state;
    logic [31:0] misc_val;
    int          count;

    always #20 radio_clk = ~radio_clk;

    // SPI loopback
    assign miso = mosi;

    radio_core_ctrl #(.PPS_CLK_FREQ(PPS_CLK_FREQ), .NUM_SLAVES(NUM_SLAVES)) i_radio_core_ctrl (
        .i_radio_clk    (radio_clk),
        .i_bus_rst      (bus_rst),
        .i_set_stb      (set_stb),
        .i_set_addr     (set_addr),
        .i_set_data     (set_data),
        .i_pps_gpsdo    (pps_gpsdo),
        .i_pps_ext      (pps_ext),
        .i_rb_misc      (rb_misc),
        .i_lock_signals (lock_signals),
        .i_miso         (miso),
        .o_sen          (sen),
        .o_sclk         (sclk),
        .o_mosi         (mosi),
        .o_spi_ready    (spi_ready),
        .o_misc_outs    (misc_outs),
        .o_pps          (pps),
        .o_time_sync    (time_sync),
        .o_rb_data      (rb_data)
    );

    bind radio_core_ctrl radio_core_ctrl_assertions #(.NUM_SLAVES(NUM_SLAVES)) u_core_sva (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_set_stb   (i_set_stb),
        .i_set_addr  (i_set_addr),
        .i_set_data  (i_set_data),
        .i_sen       (o_sen),
        .i_sclk      (o_sclk),
        .i_spi_ready (o_spi_ready),
        .i_misc_outs (o_misc_outs)
    );

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        assert (act_val === exp_val) else begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("** FAIL **");
        $fatal(1, "timeout");
    endtask

    // called and returns on a falling edge
    task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
        set_stb  = 1'b1;
        set_addr = addr;
        set_data = data;
        @(negedge radio_clk);
        set_stb  = 1'b0;
    endtask

    task automatic apply_reset();
        bus_rst = 1'b1;
        repeat (5) @(negedge radio_clk);
        bus_rst = 1'b0;
        @(negedge radio_clk);
    endtask

    // chosen pin shows up two cycles later and the other pin is ignored
    task automatic check_pps_pin(input logic [1:0] sel);
        write_setting(A_SYNC, {30'd0, sel});
        pps_gpsdo = 1'b0;
        pps_ext   = 1'b0;
        repeat (3) @(negedge radio_clk);
        check_value("pps idle", 64'd0, 64'(pps));
        if (sel == 2'd0) begin
            pps_gpsdo = 1'b1;
        end else begin
            pps_ext = 1'b1;
        end
        @(negedge radio_clk);
        check_value("pps lag", 64'd0, 64'(pps));
        @(negedge radio_clk);
        check_value("pps rise", 64'd1, 64'(pps));
        // swap the pins
        pps_gpsdo = (sel != 2'd0);
        pps_ext   = (sel == 2'd0);
        @(negedge radio_clk);
        check_value("pps hold", 64'd1, 64'(pps));
        repeat (3) begin
            @(negedge radio_clk);
            check_value("pps other pin", 64'd0, 64'(pps));
        end
        pps_gpsdo = 1'b0;
        pps_ext   = 1'b0;
    endtask

    task automatic wait_pps_change(output int cycles);
        logic start_val;
        start_val = pps;
        cycles    = 0;
        while (pps === start_val) begin
            @(negedge radio_clk);
            cycles++;
            if (cycles > 4 * PPS_CLK_FREQ) fail_timeout("an internal pps edge");
        end
    endtask

    task automatic spi_transfer(input int bits, input logic [7:0] mask);
        logic [31:0] data;
        logic        last_sclk;
        int          rises;
        int          waited;
        data = lcg_next();
        write_setting(A_SPI_CFG, {18'd0, bits[5:0], mask});
        write_setting(A_SPI_DATA, data);
        check_value("spi busy", 64'd0, 64'(spi_ready));
        rises     = 0;
        waited    = 0;
        last_sclk = sclk;
        while (!spi_ready) begin
            check_value("spi sen", {56'd0, ~mask}, 64'(sen));
            if (sclk && !last_sclk) rises++;
            last_sclk = sclk;
            @(negedge radio_clk);
            waited++;
            if (waited > 1000) fail_timeout("the SPI master to become ready");
        end
        check_value("spi sclk rises", 64'(bits), 64'(rises));
        write_setting(A_RB_SEL, 32'd1);
        check_value("spi readback", {32'd0, data >> (32 - bits)}, rb_data);
    endtask

    // bound assertion failures end the run here
    always @(negedge radio_clk) begin
        if (i_radio_core_ctrl.u_core_sva.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("** FAIL **");
            $fatal(1, "assertion failure");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        radio_clk    = 1'b0;
        set_stb      = 1'b0;
        set_addr     = 8'd0;
        set_data     = 32'd0;
        pps_gpsdo    = 1'b0;
        pps_ext      = 1'b0;
        rb_misc      = 32'd0;
        lock_signals = 2'b00;
        lcg_state    = 32'd99;
        apply_reset();

        check_value("reset word0", 64'hACE0BA5E_000D_0000, rb_data);
        check_value("reset misc", 64'd0, 64'(misc_outs));
        check_value("reset sen", 64'h00FF, 64'(sen));
        check_value("reset ready", 64'd1, 64'(spi_ready));

        // register writes
        misc_val = lcg_next();
        write_setting(A_MISC, misc_val);
        check_value("misc write", 64'(misc_val), 64'(misc_outs));
        write_setting(A_MISC + 8'd1, ~misc_val);
        write_setting(A_GPSDO_ST, 32'h0000_005A);
        check_value("misc hold", 64'(misc_val), 64'(misc_outs));
        write_setting(A_SYNC, 32'h0000_0004);
        check_value("time sync", 64'd1, 64'(time_sync));

        // readback words 2 and 3
        write_setting(A_RB_SEL, 32'd2);
        rb_misc = lcg_next();
        @(negedge radio_clk);
        check_value("word2", {16'd0, 8'h01, 8'h5A, rb_misc}, rb_data);
        lock_signals = 2'b10;
        write_setting(A_RB_SEL, 32'd3);
        count = 0;
        while (rb_data === 64'd0) begin
            @(negedge radio_clk);
            count++;
            if (count > 8) fail_timeout("lock bits in readback word 3");
        end
        check_value("word3 lock", 64'd2, rb_data);
        apply_reset();
        check_value("reset time sync", 64'd0, 64'(time_sync));
        write_setting(A_RB_SEL, 32'd2);
        check_value("gpsdo kept", 64'h5A, 64'(rb_data[39:32]));

        // pps source selection
        check_pps_pin(2'd0);
        check_pps_pin(2'd1);
        write_setting(A_SYNC, 32'd2);
        wait_pps_change(count);
        wait_pps_change(count);
        check_value("pps internal half", 64'd10, 64'(count));
        wait_pps_change(count);
        check_value("pps internal half", 64'd10, 64'(count));
        write_setting(A_SYNC, 32'd3);
        pps_gpsdo = 1'b1;
        pps_ext   = 1'b1;
        repeat (2 * PPS_CLK_FREQ) begin
            @(negedge radio_clk);
            check_value("pps none", 64'd0, 64'(pps));
        end
        pps_gpsdo = 1'b0;
        pps_ext   = 1'b0;

        // SPI transfers with a half period of 2 cycles
        write_setting(A_SPI_DIV, 32'd1);
        spi_transfer(8, 8'hA5);
        spi_transfer(32, 8'h3C);

        @(negedge radio_clk);
        if (i_radio_core_ctrl.u_core_sva.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "assertion failure");
        end
    end

endmodule
